// ==== Makefile ====
TOP = tb_executeStage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Test failures found" sim.log; then exit 1; fi
	@grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== list.f ====
+incdir+verilog
verilog/mipsPkg.sv
verilog/idExReg.sv
verilog/exDecode.sv
verilog/alu.sv
verilog/exMemReg.sv
verilog/executeStage.sv
test/executeStage_props.sv
test/executeChecker.sv
test/tb_executeStage.sv

// ==== test/executeChecker.sv ====
//************************************************************
// Execute stage monitor: reference model, expected queue,
// result comparison and error counts
//************************************************************

`timescale 1ns/1ps

`include "mips_config.svh"

module executeChecker
(
    input  logic               i_clk,
    input  logic               i_rstN,
    input  logic               i_valid,
    input  logic               i_flush,
    input  mipsPkg::exInstr_t  i_instr,
    input  logic               i_outValid,   // DUT o_valid
    input  mipsPkg::exResult_t i_outResult,  // DUT o_result
    output int                 o_errors,
    output int                 o_checks,
    output int                 o_pending     // Queue depth
);

    import mipsPkg::*;

    exResult_t expQ [$];
    int        cycQ [$];   // Issue edge of each entry
    string     nameQ [$];
    int        cycle;

    // Expected result from the stage rules
    function automatic exResult_t refExecute(input exInstr_t ins);
        logic [5:0] op;
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        exResult_t  r;
        case (ins.aluClass)
            CLS_ADD:  op = 6'h21;          // ADDU
            CLS_SUB:  op = 6'h23;          // SUBU
            CLS_SLTI: op = 6'h2a;          // SLT
            default:  op = ins.funct;
        endcase
        a = ins.rsData;
        b = ins.useImm ? ins.imm : ins.rtData;
        sh = ins.shamt;
        if (op == 6'h00 || op == 6'h02 || op == 6'h03)
            a = ins.rtData;                // Shift by shamt
        if (op == 6'h04 || op == 6'h06 || op == 6'h07)
        begin
            a  = ins.rtData;
            sh = ins.rsData[4:0];          // Only low 5 bits of rs
        end
        case (op)
            6'h20, 6'h21: r.result = a + b;
            6'h22, 6'h23: r.result = a - b;
            6'h24:        r.result = a & b;
            6'h25:        r.result = a | b;
            6'h26:        r.result = a ^ b;
            6'h27:        r.result = ~(a | b);
            6'h00, 6'h04: r.result = a << sh;
            6'h02, 6'h06: r.result = a >> sh;
            6'h03, 6'h07: r.result = word_t'($signed(a) >>> sh);
            6'h2a:        r.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:      r.result = '0;   // Unknown funct
        endcase
        r.rd       = ins.rd;
        r.regWrite = ins.regWrite && (ins.rd != '0);
        return r;
    endfunction

    function automatic string opName(input exInstr_t ins);
        case (ins.aluClass)
            CLS_ADD:  return "class ADD";
            CLS_SUB:  return "class SUB";
            CLS_SLTI: return "class SLTI";
            default:  return $sformatf("rtype funct %02h", ins.funct);
        endcase
    endfunction

    always @(posedge i_clk or negedge i_rstN)
    begin
        exResult_t exp;
        int        issued;
        string     name;
        if (!i_rstN)
        begin
            cycle = 0;
            expQ.delete();
            cycQ.delete();
            nameQ.delete();
            o_errors  = 0;
            o_checks  = 0;
            o_pending = 0;
        end
        else
        begin
            cycle++;
            if (i_outValid)
            begin
                if (expQ.size() == 0)
                begin
                    $display("ERROR: output valid at cycle %0d with nothing in flight", cycle);
                    o_errors++;
                end
                else
                begin
                    exp    = expQ.pop_front();
                    issued = cycQ.pop_front();
                    name   = nameQ.pop_front();
                    o_checks++;
                    if (cycle - issued != 2)
                    begin
                        $display("ERROR: %s result came %0d edges after issue instead of 2",
                                 name, cycle - issued);
                        o_errors++;
                    end
                    if (i_outResult !== exp)
                    begin
                        $display("FAIL %s expected %h actual %h", name, exp, i_outResult);
                        o_errors++;
                    end
                end
            end
            if (i_valid && !i_flush)       // Flushed instr never arrives
            begin
                expQ.push_back(refExecute(i_instr));
                cycQ.push_back(cycle);
                nameQ.push_back(opName(i_instr));
            end
            o_pending = expQ.size();
        end
    end

endmodule

// ==== test/executeStage_props.sv ====
//************************************************************
// Concurrent assertions for executeStage, attached by bind
//************************************************************

`timescale 1ns/1ps

module executeStage_props
(
    input logic               i_clk,
    input logic               i_rstN,
    input logic               i_valid,
    input logic               i_flush,
    input logic               o_valid,
    input mipsPkg::exResult_t o_result
);

    logic seenValid;  // Some instr sampled since reset

    always_ff @(posedge i_clk or negedge i_rstN)
    begin
        if (!i_rstN)
        begin
            seenValid <= 1'b0;
        end
        else if (i_valid)
        begin
            seenValid <= 1'b1;  // First instr now in flight
        end
    end

    // Quiet until the first instr has had two edges
    startupQuiet: assert property (@(posedge i_clk) disable iff (!i_rstN)
        !$past(seenValid) |-> !o_valid)
        else $error("o_valid high before any instruction could reach the output");

    // Two-cycle latency, flushed instr dropped
    latencyTwo: assert property (@(posedge i_clk) disable iff (!i_rstN)
        o_valid == $past(i_valid && !i_flush, 2))
        else $error("o_valid does not follow i_valid two cycles later");

    noWriteR0: assert property (@(posedge i_clk) disable iff (!i_rstN)
        o_result.regWrite |-> (o_result.rd != '0))
        else $error("regWrite high with destination register 0");

endmodule

bind executeStage executeStage_props props (
    .i_clk    (i_clk),
    .i_rstN   (i_rstN),
    .i_valid  (i_valid),
    .i_flush  (i_flush),
    .o_valid  (o_valid),
    .o_result (o_result)
);

// ==== test/tb_executeStage.sv ====
//************************************************************
// Testbench for executeStage: clock, reset, random stimulus,
// watchdog and final report
//************************************************************

`timescale 1ns/1ps

module tb_executeStage;

    import mipsPkg::*;

    localparam int RAND_N      = 6;                             // Random cases per op
    localparam int PLAN_CYCLES = 14 * RAND_N + 40;              // Issued cycles, all tests
    localparam int TIMEOUT_NS  = (PLAN_CYCLES + 5 + 100) * 8;   // Plus reset and margin

    logic        i_clk;
    logic        i_rstN;
    logic        i_valid;
    logic        i_flush;
    exInstr_t    i_instr;
    logic        o_valid;
    exResult_t   o_result;
    logic [31:0] rngState;     // Xorshift state
    int          errors;
    int          checks;
    int          pending;      // Results still in flight
    aluFunct_t   arithOps [8];
    aluFunct_t   shiftOps [6];

    executeStage dut (.*);

    executeChecker chk (
        .i_clk       (i_clk),
        .i_rstN      (i_rstN),
        .i_valid     (i_valid),
        .i_flush     (i_flush),
        .i_instr     (i_instr),
        .i_outValid  (o_valid),
        .i_outResult (o_result),
        .o_errors    (errors),
        .o_checks    (checks),
        .o_pending   (pending)
    );

    always #4 i_clk = ~i_clk;  // 8 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic exInstr_t makeInstr(input aluClass_t c, input aluFunct_t f,
                                           input shamt_t s, input logic u, input word_t rs,
                                           input word_t rt, input word_t im,
                                           input regAddr_t rd, input logic w);
        exInstr_t ins;
        ins.aluClass = c;
        ins.funct    = f;
        ins.shamt    = s;
        ins.useImm   = u;
        ins.rsData   = rs;
        ins.rtData   = rt;
        ins.imm      = im;
        ins.rd       = rd;
        ins.regWrite = w;
        return ins;
    endfunction

    // One cycle of input drive
    task automatic drive(input logic v, input exInstr_t ins, input logic f);
        @(posedge i_clk);
        i_valid <= v;
        i_instr <= ins;
        i_flush <= f;
    endtask

    task automatic issue(input exInstr_t ins);
        drive(1'b1, ins, 1'b0);
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge i_clk);
            i_valid <= 1'b0;
            i_flush <= 1'b0;
        end
    endtask

    // Watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        word_t rt;
        i_clk    = 1'b0;
        i_rstN   = 1'b0;
        i_valid  = 1'b0;
        i_flush  = 1'b0;
        i_instr  = '0;
        rngState = 32'd50019;
        arithOps = '{ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR};
        shiftOps = '{SLL, SRL, SRA, SLLV, SRLV, SRAV};
        repeat (5) @(posedge i_clk);
        i_rstN <= 1'b1;
        idle(3);                                        // o_valid must stay low
        // R-type arithmetic and logic
        for (int i = 0; i < 8; i++)
            for (int j = 0; j < RAND_N; j++)
                issue(makeInstr(CLS_RTYPE, arithOps[i], 5'(nextRand()), 1'b0, nextRand(),
                                nextRand(), nextRand(), 5'(nextRand()), 1'b1));
        issue(makeInstr(CLS_RTYPE, ADD, 0, 0, 32'h7fff_ffff, 32'h1, 0, 5'd3, 1'b1));
        issue(makeInstr(CLS_RTYPE, SUBU, 0, 0, 32'h8000_0000, 32'h1, 0, 5'd4, 1'b1));
        // Shifts, negative values on odd cases
        for (int i = 0; i < 6; i++)
            for (int j = 0; j < RAND_N; j++)
            begin
                rt = nextRand() | (j[0] ? 32'h8000_0000 : 32'h0);
                issue(makeInstr(CLS_RTYPE, shiftOps[i], 5'(nextRand()), 1'b0, nextRand(),
                                rt, 0, 5'(nextRand()), 1'b1));
            end
        // Operation classes
        issue(makeInstr(CLS_ADD, SLT, 0, 1'b1, nextRand(), nextRand(), 32'hffff_fff0, 5'd8, 1));
        issue(makeInstr(CLS_ADD, AND, 0, 1'b0, nextRand(), nextRand(), nextRand(), 5'd9, 1));
        issue(makeInstr(CLS_SUB, OR, 0, 1'b0, 32'd5, 32'd7, 0, 5'd10, 1'b0));
        issue(makeInstr(CLS_SUB, XOR, 0, 1'b1, nextRand(), nextRand(), 32'h0000_7fff, 5'd11, 1));
        issue(makeInstr(CLS_SLTI, ADD, 0, 1'b1, 32'hffff_ffff, 0, 32'h0, 5'd12, 1'b1));
        issue(makeInstr(CLS_SLTI, ADD, 0, 1'b1, 32'h8000_0000, 0, 32'h7fff_ffff, 5'd13, 1'b1));
        issue(makeInstr(CLS_SLTI, ADD, 0, 1'b1, 32'd5, 0, 32'd5, 5'd14, 1'b1));
        issue(makeInstr(CLS_SLTI, ADD, 0, 1'b1, 32'h7fff_ffff, 0, 32'hffff_ffff, 5'd15, 1'b1));
        issue(makeInstr(CLS_RTYPE, SLT, 0, 1'b0, 32'hffff_fffe, 32'd1, 0, 5'd16, 1'b1));
        issue(makeInstr(CLS_RTYPE, SLT, 0, 1'b0, 32'd1, 32'hffff_fffe, 0, 5'd17, 1'b1));
        // Write qualification and unknown funct
        issue(makeInstr(CLS_RTYPE, ADDU, 0, 1'b0, nextRand(), nextRand(), 0, 5'd0, 1'b1));
        issue(makeInstr(CLS_RTYPE, aluFunct_t'(6'h3f), 0, 0, nextRand(), nextRand(), 0, 5'd18, 1));
        issue(makeInstr(CLS_RTYPE, aluFunct_t'(6'h01), 0, 0, nextRand(), nextRand(), 0, 5'd19, 0));
        // Pipeline flow with gaps and flush
        idle(2);
        issue(makeInstr(CLS_ADD, ADD, 0, 1'b1, 32'd100, 0, 32'd1, 5'd20, 1'b1));
        drive(1'b1, makeInstr(CLS_ADD, ADD, 0, 1'b1, 32'd200, 0, 32'd2, 5'd21, 1'b1), 1'b1);
        issue(makeInstr(CLS_ADD, ADD, 0, 1'b1, 32'd300, 0, 32'd3, 5'd22, 1'b1));
        drive(1'b0, '0, 1'b1);                          // Flush an empty slot
        issue(makeInstr(CLS_SUB, ADD, 0, 1'b0, 32'd9, 32'd4, 0, 5'd23, 1'b1));
        idle(1);
        wait (pending == 0);
        repeat (3) @(posedge i_clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verilog/alu.sv ====
//************************************************************
// Combinational funct-coded arithmetic-logic unit
//************************************************************

`timescale 1ns/1ps

`include "mips_config.svh"

module alu
(
    input  mipsPkg::aluFunct_t i_op,      // Operation code
    input  mipsPkg::word_t     i_opA,     // Operand A
    input  mipsPkg::word_t     i_opB,     // Operand B
    output mipsPkg::word_t     o_result   // Result word
);

    import mipsPkg::*;

    shamt_t shAmt;  // Low bits of B only

    assign shAmt = i_opB[`SHAMT_W-1:0];  // MIPS shift semantics

    always_comb
    begin
        case (i_op)
            ADD, ADDU:
            begin
                o_result = i_opA + i_opB;  // Same bits signed or not
            end
            SUB, SUBU:
            begin
                o_result = i_opA - i_opB;  // Wraps on overflow
            end
            AND:        o_result = i_opA & i_opB;
            OR:         o_result = i_opA | i_opB;
            XOR:        o_result = i_opA ^ i_opB;
            NOR:        o_result = ~(i_opA | i_opB);
            SLL, SLLV:
            begin
                o_result = i_opA << shAmt;  // Zero fill
            end
            SRL, SRLV:
            begin
                o_result = i_opA >> shAmt;  // Zero fill
            end
            SRA, SRAV:
            begin
                o_result = $signed(i_opA) >>> shAmt;  // Sign fill
            end
            SLT:
            begin
                // One or zero, compared as signed
                o_result = {{(`WORD_W - 1){1'b0}}, ($signed(i_opA) < $signed(i_opB))};
            end
            default:
            begin
                o_result = '0;  // Unknown funct
            end
        endcase
    end

endmodule

// ==== verilog/exDecode.sv ====
//************************************************************
// ALU control decode and operand selection
//************************************************************

`timescale 1ns/1ps

`include "mips_config.svh"

module exDecode
(
    input  mipsPkg::exInstr_t  i_instr,  // Instruction from ID/EX
    output mipsPkg::aluFunct_t o_aluOp,  // Resolved ALU operation
    output mipsPkg::word_t     o_opA,    // ALU operand A
    output mipsPkg::word_t     o_opB     // ALU operand B
);

    import mipsPkg::*;

    word_t shamtExt;  // Zero-extended shift field

    assign shamtExt = {{(`WORD_W - `SHAMT_W){1'b0}}, i_instr.shamt};

    // Class to operation
    always_comb
    begin
        case (i_instr.aluClass)
            CLS_ADD:
            begin
                o_aluOp = ADDU;  // Address add, never traps
            end
            CLS_SUB:
            begin
                o_aluOp = SUBU;  // Branch compare
            end
            CLS_SLTI:
            begin
                o_aluOp = SLT;   // Signed compare
            end
            default:
            begin
                o_aluOp = i_instr.funct;  // R-type passes funct
            end
        endcase
    end

    // Operand routing follows resolved op
    always_comb
    begin
        case (o_aluOp)
            SLL, SRL, SRA:
            begin
                o_opA = i_instr.rtData;  // Shift the rt value
                o_opB = shamtExt;        // By the shamt field
            end
            SLLV, SRLV, SRAV:
            begin
                o_opA = i_instr.rtData;  // Shift the rt value
                o_opB = i_instr.rsData;  // By rs, low bits used
            end
            default:
            begin
                o_opA = i_instr.rsData;
                o_opB = i_instr.useImm ? i_instr.imm : i_instr.rtData;  // I or R form
            end
        endcase
    end

endmodule

// ==== verilog/exMemReg.sv ====
//************************************************************
// EX/MEM result register with write qualification
//************************************************************

`timescale 1ns/1ps

module exMemReg
(
    input  logic               i_clk,       // Pipeline clock
    input  logic               i_rstN,      // Async reset, active low
    input  logic               i_valid,     // Live instr in EX
    input  mipsPkg::regAddr_t  i_rd,        // Destination register
    input  logic               i_regWrite,  // Write requested
    input  mipsPkg::word_t     i_result,    // ALU result
    output logic               o_valid,     // Result valid
    output mipsPkg::exResult_t o_result     // Registered result
);

    import mipsPkg::*;

    word_t    resultQ;    // Payload, no reset
    regAddr_t rdQ;        // Payload, no reset
    logic     regWriteQ;  // Control, reset

    always_ff @(posedge i_clk or negedge i_rstN)
    begin
        if (!i_rstN)
        begin
            o_valid   <= 1'b0;
            regWriteQ <= 1'b0;
        end
        else
        begin
            o_valid   <= i_valid;
            regWriteQ <= i_valid & i_regWrite & (i_rd != '0);  // r0 is never written
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            resultQ <= i_result;  // Only live results load
            rdQ     <= i_rd;
        end
    end

    assign o_result = '{result: resultQ, rd: rdQ, regWrite: regWriteQ};

endmodule

// ==== verilog/executeStage.sv ====
//************************************************************
// Execute stage top: ID/EX, decode, ALU, EX/MEM
//************************************************************

`timescale 1ns/1ps

module executeStage
(
    input  logic               i_clk,     // Pipeline clock
    input  logic               i_rstN,    // Async reset, active low
    input  logic               i_valid,   // Instruction present
    input  logic               i_flush,   // Kill instr entering ID/EX
    input  mipsPkg::exInstr_t  i_instr,   // Decoded instruction
    output logic               o_valid,   // Result valid, 2 cycles later
    output mipsPkg::exResult_t o_result   // Result to MEM
);

    import mipsPkg::*;

    logic      exValid;    // ID/EX slot live
    exInstr_t  exInstr;    // Instruction in EX
    aluFunct_t aluOp;      // Resolved operation
    word_t     opA;
    word_t     opB;
    word_t     aluResult;  // Combinational result

    idExReg uIdEx (
        .i_clk   (i_clk),
        .i_rstN  (i_rstN),
        .i_valid (i_valid),
        .i_flush (i_flush),
        .i_instr (i_instr),
        .o_valid (exValid),
        .o_instr (exInstr)
    );

    exDecode uDecode (
        .i_instr (exInstr),
        .o_aluOp (aluOp),
        .o_opA   (opA),
        .o_opB   (opB)
    );

    alu uAlu (
        .i_op     (aluOp),
        .i_opA    (opA),
        .i_opB    (opB),
        .o_result (aluResult)
    );

    exMemReg uExMem (
        .i_clk      (i_clk),
        .i_rstN     (i_rstN),
        .i_valid    (exValid),
        .i_rd       (exInstr.rd),
        .i_regWrite (exInstr.regWrite),
        .i_result   (aluResult),
        .o_valid    (o_valid),
        .o_result   (o_result)
    );

endmodule

// ==== verilog/idExReg.sv ====
//************************************************************
// ID/EX pipeline register with valid bit and flush
//************************************************************

`timescale 1ns/1ps

module idExReg
(
    input  logic              i_clk,    // Pipeline clock
    input  logic              i_rstN,   // Async reset, active low
    input  logic              i_valid,  // Instruction present
    input  logic              i_flush,  // Kill slot this edge
    input  mipsPkg::exInstr_t i_instr,  // Decoded instruction
    output logic              o_valid,  // Slot holds live instr
    output mipsPkg::exInstr_t o_instr   // Held instruction
);

    // Valid bit, flush beats capture
    always_ff @(posedge i_clk or negedge i_rstN)
    begin
        if (!i_rstN)
        begin
            o_valid <= 1'b0;                // Empty after reset
        end
        else
        begin
            o_valid <= i_valid & ~i_flush;  // Flush empties slot
        end
    end

    // Payload only moves on a real instruction
    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            o_instr <= i_instr;  // Hold otherwise, less toggling
        end
    end

endmodule

// ==== verilog/mipsPkg.sv ====
//************************************************************
// Execute stage types: words, funct codes, pipeline structs
//************************************************************

`include "mips_config.svh"

package mipsPkg;

    typedef logic [`WORD_W-1:0]  word_t;     // Data word
    typedef logic [`REG_W-1:0]   regAddr_t;  // Register number
    typedef logic [`SHAMT_W-1:0] shamt_t;    // Shift amount

    typedef enum logic [5:0] {
        SLL  = 6'b000000,  // Shift left by shamt
        SRL  = 6'b000010,  // Shift right logic by shamt
        SRA  = 6'b000011,  // Shift right arith by shamt
        SLLV = 6'b000100,  // Shift left by rs
        SRLV = 6'b000110,  // Shift right logic by rs
        SRAV = 6'b000111,  // Shift right arith by rs
        ADD  = 6'b100000,  // Signed add, no trap here
        ADDU = 6'b100001,  // Unsigned add
        SUB  = 6'b100010,  // Signed subtract, no trap here
        SUBU = 6'b100011,  // Unsigned subtract
        AND  = 6'b100100,  // Bitwise and
        OR   = 6'b100101,  // Bitwise or
        XOR  = 6'b100110,  // Bitwise xor
        NOR  = 6'b100111,  // Bitwise nor
        SLT  = 6'b101010   // Set on signed less than
    } aluFunct_t;

    typedef enum logic [1:0] {
        CLS_ADD   = 2'd0,  // Load/store address
        CLS_SUB   = 2'd1,  // Branch compare
        CLS_RTYPE = 2'd2,  // Operation from funct
        CLS_SLTI  = 2'd3   // Signed compare with immediate
    } aluClass_t;

    typedef struct packed {
        aluClass_t aluClass;  // Operation class
        aluFunct_t funct;     // R-type funct field
        shamt_t    shamt;     // Shift amount field
        logic      useImm;    // B from immediate
        word_t     rsData;    // Source register value
        word_t     rtData;    // Target register value
        word_t     imm;       // Sign-extended immediate
        regAddr_t  rd;        // Destination register
        logic      regWrite;  // Write requested
    } exInstr_t;

    typedef struct packed {
        word_t    result;    // ALU result
        regAddr_t rd;        // Destination register
        logic     regWrite;  // Qualified write enable
    } exResult_t;

endpackage

// ==== verilog/mips_config.svh ====
//************************************************************
// Width macros for the execute stage datapath
//************************************************************

`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Operand and result width
`define WORD_W 32

// Register number width, 32 registers
`define REG_W 5

// Shift amount width, low bits of B
`define SHAMT_W 5

`endif
